//--- src.f
+incdir+sim
hw/burst_pkg.sv
hw/burst_reader.sv
hw/burst_writer.sv
hw/line_fill_arbiter.sv
hw/line_fill_top.sv
sim/line_fill_props.sv
sim/tb_line_fill.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_line_fill
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= >>> FAIL
VFLAGS    ?= --binary --timing --assert --timescale 1ns/10ps -j 0

BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: compile
	@$(BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -qF -- '$(FAIL_MSG)' $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- sim/tb_line_fill_tests.svh
// expected line for a line address under the memory rule
function automatic line_t memory_line(input addr_t line_addr);
    line_t exp_line;
    for (int k = 0; k < BEATS_PER_LINE; k++) begin
        exp_line[k*BEAT_BITS +: BEAT_BITS] = {line_addr, 32'(k)};
    end
    return exp_line;
endfunction

task automatic check_line(input string name, input line_t exp, input line_t act);
    if (act !== exp) begin
        $display("ERROR %0t %s expected %h got %h", $time, name, exp, act);
        err_count++;
    end
endtask

task automatic check_beat(input string name, input beat_t exp, input beat_t act);
    if (act !== exp) begin
        $display("ERROR %0t %s expected %h got %h", $time, name, exp, act);
        err_count++;
    end
endtask

task automatic check_addr(input string name, input addr_t exp, input addr_t act);
    if (act !== exp) begin
        $display("ERROR %0t %s expected %h got %h", $time, name, exp, act);
        err_count++;
    end
endtask

task automatic expect_low(input string name, input logic act);
    if (act !== 1'b0) begin
        $display("ERROR %0t %s expected 0 got %b", $time, name, act);
        err_count++;
    end
endtask

// the other client's resp must stay low while we wait
task automatic await_response(input logic dside, output line_t rdata);
    int   n   = 0;
    logic got = 1'b0;
    rdata = '0;
    while (!got && n < RSP_LIMIT) begin
        @(negedge clk);
        n++;
        if (dside) begin
            expect_low("icache_rsp_o.resp", icache_rsp_o.resp);
        end else begin
            expect_low("dcache_rsp_o.resp", dcache_rsp_o.resp);
        end
        if (dside ? dcache_rsp_o.resp : icache_rsp_o.resp) begin
            got   = 1'b1;
            rdata = dside ? dcache_rsp_o.rdata : icache_rsp_o.rdata;
        end
    end
    if (!got) begin
        $display("no response arrived within %0d cycles", RSP_LIMIT);
        err_count++;
    end
endtask

task automatic report_test(input string name, input int errs_before);
    tests_run++;
    if (err_count == errs_before) begin
        $display("%s: ok", name);
    end else begin
        tests_failed++;
        $display("%s: failed", name);
    end
endtask

task automatic idle_stays_quiet();
    int errs = err_count;
    repeat (20) begin
        @(negedge clk);
        expect_low("bmem_read_o", bmem_read_o);
        expect_low("bmem_write_o", bmem_write_o);
        expect_low("icache_rsp_o.resp", icache_rsp_o.resp);
        expect_low("dcache_rsp_o.resp", dcache_rsp_o.resp);
    end
    report_test("idle_stays_quiet", errs);
endtask

// base is req with the line offset cleared by hand
task automatic line_read(input string name, input logic dside, input addr_t req,
                         input addr_t base);
    int    errs = err_count;
    line_t rdata;
    rd_addrs.delete();
    if (dside) begin
        dcache_req_i.addr = req;
        dcache_req_i.read = 1'b1;
    end else begin
        icache_addr_i = req;
        icache_read_i = 1'b1;
    end
    await_response(dside, rdata);
    dcache_req_i.read = 1'b0;
    icache_read_i     = 1'b0;
    check_line($sformatf("%s_rsp_o.rdata", dside ? "dcache" : "icache"), memory_line(base),
               rdata);
    check_addr("bmem_addr_o", base, rd_addrs[0]);
    repeat (2) @(negedge clk);
    report_test(name, errs);
endtask

task automatic dcache_line_write();
    int    errs = err_count;
    line_t wdata;
    line_t rdata;
    for (int w = 0; w < LINE_BITS / 32; w++) begin
        wdata[w*32 +: 32] = $random(seed);
    end
    wr_beats.delete();
    wr_addrs.delete();
    dcache_req_i.addr  = 32'h8000_0047;
    dcache_req_i.wdata = wdata;
    dcache_req_i.write = 1'b1;
    await_response(1'b1, rdata);
    dcache_req_i.write = 1'b0;
    // a fifth beat would show up here
    repeat (4) @(negedge clk);
    if (wr_beats.size() != BEATS_PER_LINE) begin
        $display("write burst gave %0d accepted beats instead of %0d", wr_beats.size(),
                 BEATS_PER_LINE);
        err_count++;
    end else begin
        for (int k = 0; k < BEATS_PER_LINE; k++) begin
            check_beat($sformatf("bmem_wdata_o beat %0d", k), wdata[k*BEAT_BITS +: BEAT_BITS],
                       wr_beats[k]);
            check_addr("bmem_addr_o", 32'h8000_0040, wr_addrs[k]);
        end
    end
    report_test("dcache_line_write", errs);
endtask

task automatic dcache_before_icache();
    int    errs = err_count;
    line_t rdata;
    rd_addrs.delete();
    dcache_req_i.addr = 32'h0000_2f3f;
    dcache_req_i.read = 1'b1;
    icache_addr_i     = 32'h0001_0010;
    icache_read_i     = 1'b1;
    await_response(1'b1, rdata);
    dcache_req_i.read = 1'b0;
    check_line("dcache_rsp_o.rdata", memory_line(32'h0000_2f20), rdata);
    await_response(1'b0, rdata);
    icache_read_i = 1'b0;
    check_line("icache_rsp_o.rdata", memory_line(32'h0001_0000), rdata);
    check_addr("first bmem_addr_o", 32'h0000_2f20, rd_addrs[0]);
    repeat (2) @(negedge clk);
    report_test("dcache_before_icache", errs);
endtask

//--- sim/tb_line_fill.sv
`timescale 1ns/10ps

module tb_line_fill;
    import burst_pkg::*;

    localparam int CLK_PERIOD = 8;
    localparam int NUM_TESTS  = 5;
    localparam int RSP_LIMIT  = 100;

    logic        clk;
    logic        rst;
    addr_t       icache_addr_i;
    logic        icache_read_i;
    dcache_req_t dcache_req_i;
    logic        bmem_ready_i;
    logic        bmem_rvalid_i;
    addr_t       bmem_raddr_i;
    beat_t       bmem_rdata_i;
    line_rsp_t   icache_rsp_o;
    line_rsp_t   dcache_rsp_o;
    addr_t       bmem_addr_o;
    logic        bmem_read_o;
    logic        bmem_write_o;
    beat_t       bmem_wdata_o;

    int    seed         = 6826;
    int    err_count    = 0;
    int    tests_run    = 0;
    int    tests_failed = 0;
    addr_t rd_addrs[$];
    addr_t wr_addrs[$];
    beat_t wr_beats[$];

    line_fill_top dut (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // burst memory: four beats per read, beat k is {line address, k}
    task automatic serve_read(input addr_t addr);
        int gap;
        rd_addrs.push_back(addr);
        for (int k = 0; k < BEATS_PER_LINE; k++) begin
            gap = $unsigned($random(seed)) % 4;
            @(negedge clk);
            bmem_rvalid_i = 1'b0;
            repeat (gap) @(negedge clk);
            bmem_rvalid_i = 1'b1;
            bmem_raddr_i  = addr;
            bmem_rdata_i  = {addr, 32'(k)};
        end
        @(negedge clk);
        bmem_rvalid_i = 1'b0;
    endtask

    always @(negedge clk) begin
        if (!rst && bmem_read_o) begin
            serve_read(bmem_addr_o);
        end
    end

    // memory busy on about one cycle in four
    always @(negedge clk) begin
        if (!rst) begin
            bmem_ready_i = ($unsigned($random(seed)) % 4) != 0;
        end
    end

    // a write beat counts when write and ready meet at the clock edge
    always @(posedge clk) begin
        if (!rst && bmem_write_o && bmem_ready_i) begin
            wr_beats.push_back(bmem_wdata_o);
            wr_addrs.push_back(bmem_addr_o);
        end
    end

    `include "tb_line_fill_tests.svh"

    initial begin
        #(NUM_TESTS * 200 * CLK_PERIOD);
        $display("timeout: tests still running after %0d cycles", NUM_TESTS * 200);
        $display(">>> FAIL");
        $finish;
    end

    initial begin
        rst           = 1'b1;
        icache_addr_i = '0;
        icache_read_i = 1'b0;
        dcache_req_i  = '0;
        bmem_ready_i  = 1'b1;
        bmem_rvalid_i = 1'b0;
        bmem_raddr_i  = '0;
        bmem_rdata_i  = '0;
        // two rising edges under reset, then release on a falling edge
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        idle_stays_quiet();
        line_read("icache_line_read", 1'b0, 32'h0000_1234, 32'h0000_1220);
        line_read("dcache_line_read", 1'b1, 32'h4000_0abc, 32'h4000_0aa0);
        dcache_line_write();
        dcache_before_icache();
        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, err_count);
        if (err_count == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

//--- sim/line_fill_props.sv
`timescale 1ns/10ps

module line_fill_props (
    input logic                 clk,
    input logic                 rst,
    input logic                 bmem_read_o,
    input logic                 bmem_write_o,
    input logic                 bmem_ready_i,
    input burst_pkg::beat_t     bmem_wdata_o,
    input burst_pkg::line_rsp_t icache_rsp_o,
    input burst_pkg::line_rsp_t dcache_rsp_o
);
    import burst_pkg::*;

    read_pulse: assert property (@(posedge clk) disable iff (rst)
        bmem_read_o |=> !bmem_read_o)
        else $error("bmem_read_o high for two cycles");

    no_read_write: assert property (@(posedge clk) disable iff (rst)
        !(bmem_read_o && bmem_write_o))
        else $error("bmem_read_o and bmem_write_o high together");

    // stalled beat must wait unchanged
    beat_held: assert property (@(posedge clk) disable iff (rst)
        bmem_write_o && !bmem_ready_i |=> $stable(bmem_wdata_o))
        else $error("bmem_wdata_o changed while memory was not ready");

    one_resp: assert property (@(posedge clk) disable iff (rst)
        !(icache_rsp_o.resp && dcache_rsp_o.resp))
        else $error("both clients got resp in the same cycle");

endmodule

bind line_fill_top line_fill_props u_props (.*);

//--- hw/line_fill_top.sv
`timescale 1ns/10ps

module line_fill_top (
    input  logic                   clk,
    input  logic                   rst,
    input  burst_pkg::addr_t       icache_addr_i,
    input  logic                   icache_read_i,
    input  burst_pkg::dcache_req_t dcache_req_i,
    input  logic                   bmem_ready_i,
    input  logic                   bmem_rvalid_i,
    input  burst_pkg::addr_t       bmem_raddr_i,
    input  burst_pkg::beat_t       bmem_rdata_i,
    output burst_pkg::line_rsp_t   icache_rsp_o,
    output burst_pkg::line_rsp_t   dcache_rsp_o,
    output burst_pkg::addr_t       bmem_addr_o,
    output logic                   bmem_read_o,
    output logic                   bmem_write_o,
    output burst_pkg::beat_t       bmem_wdata_o
);
    import burst_pkg::*;

    logic  write_start;
    line_t write_line;
    logic  write_done;
    line_t read_line;
    logic  read_done;

    // bmem_raddr_i stays unconnected, one read in flight at most
    line_fill_arbiter u_arbiter (
        .clk           (clk),
        .rst           (rst),
        .icache_addr_i (icache_addr_i),
        .icache_read_i (icache_read_i),
        .dcache_req_i  (dcache_req_i),
        .bmem_ready_i  (bmem_ready_i),
        .read_done_i   (read_done),
        .read_line_i   (read_line),
        .write_done_i  (write_done),
        .bmem_addr_o   (bmem_addr_o),
        .bmem_read_o   (bmem_read_o),
        .write_start_o (write_start),
        .write_line_o  (write_line),
        .icache_rsp_o  (icache_rsp_o),
        .dcache_rsp_o  (dcache_rsp_o)
    );

    burst_reader u_reader (
        .clk           (clk),
        .rst           (rst),
        .bmem_rvalid_i (bmem_rvalid_i),
        .bmem_rdata_i  (bmem_rdata_i),
        .read_line_o   (read_line),
        .read_done_o   (read_done)
    );

    burst_writer u_writer (
        .clk           (clk),
        .rst           (rst),
        .write_start_i (write_start),
        .write_line_i  (write_line),
        .bmem_ready_i  (bmem_ready_i),
        .bmem_write_o  (bmem_write_o),
        .bmem_wdata_o  (bmem_wdata_o),
        .write_done_o  (write_done)
    );

endmodule

//--- hw/line_fill_arbiter.sv
`timescale 1ns/10ps

module line_fill_arbiter (
    input  logic                   clk,
    input  logic                   rst,
    input  burst_pkg::addr_t       icache_addr_i,
    input  logic                   icache_read_i,
    input  burst_pkg::dcache_req_t dcache_req_i,
    input  logic                   bmem_ready_i,
    input  logic                   read_done_i,
    input  burst_pkg::line_t       read_line_i,
    input  logic                   write_done_i,
    output burst_pkg::addr_t       bmem_addr_o,
    output logic                   bmem_read_o,
    output logic                   write_start_o,
    output burst_pkg::line_t       write_line_o,
    output burst_pkg::line_rsp_t   icache_rsp_o,
    output burst_pkg::line_rsp_t   dcache_rsp_o
);
    import burst_pkg::*;

    arb_state_e state_q;
    arb_state_e state_d;
    logic       grant_i_read;
    logic       grant_d_read;
    logic       grant_d_write;

    // clear the byte offset so the memory sees a line address
    function automatic addr_t line_align(input addr_t addr);
        return {addr[ADDR_BITS-1:LINE_OFFSET_BITS], {LINE_OFFSET_BITS{1'b0}}};
    endfunction

    always_comb begin
        state_d       = state_q;
        grant_i_read  = 1'b0;
        grant_d_read  = 1'b0;
        grant_d_write = 1'b0;
        unique case (state_q)
            ARB_IDLE: begin
                // data side wins; a waiting data read also blocks fetch
                if (dcache_req_i.write) begin
                    grant_d_write = 1'b1;
                    state_d       = ARB_WRITE_D;
                end else if (dcache_req_i.read) begin
                    if (bmem_ready_i) begin
                        grant_d_read = 1'b1;
                        state_d      = ARB_READ_D;
                    end
                end else if (icache_read_i && bmem_ready_i) begin
                    grant_i_read = 1'b1;
                    state_d      = ARB_READ_I;
                end
            end
            ARB_READ_I, ARB_READ_D: begin
                if (read_done_i) begin
                    state_d = ARB_IDLE;
                end
            end
            ARB_WRITE_D: begin
                if (write_done_i) begin
                    state_d = ARB_IDLE;
                end
            end
            default: state_d = ARB_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q       <= ARB_IDLE;
            bmem_read_o   <= 1'b0;
            write_start_o <= 1'b0;
        end else begin
            state_q       <= state_d;
            bmem_read_o   <= grant_i_read | grant_d_read;
            write_start_o <= grant_d_write;
        end
    end

    // address and write line captured once at the grant
    always_ff @(posedge clk) begin
        if (grant_d_read || grant_d_write) begin
            bmem_addr_o <= line_align(dcache_req_i.addr);
        end else if (grant_i_read) begin
            bmem_addr_o <= line_align(icache_addr_i);
        end
        if (grant_d_write) begin
            write_line_o <= dcache_req_i.wdata;
        end
    end

    // resp goes out in the same cycle as the done pulse
    always_comb begin
        icache_rsp_o.resp  = (state_q == ARB_READ_I) && read_done_i;
        icache_rsp_o.rdata = (state_q == ARB_READ_I) ? read_line_i : '0;
        dcache_rsp_o.resp  = ((state_q == ARB_READ_D) && read_done_i) ||
                             ((state_q == ARB_WRITE_D) && write_done_i);
        dcache_rsp_o.rdata = (state_q == ARB_READ_D) ? read_line_i : '0;
    end

endmodule

//--- hw/burst_writer.sv
`timescale 1ns/10ps

module burst_writer (
    input  logic             clk,
    input  logic             rst,
    input  logic             write_start_i,
    input  burst_pkg::line_t write_line_i,
    input  logic             bmem_ready_i,
    output logic             bmem_write_o,
    output burst_pkg::beat_t bmem_wdata_o,
    output logic             write_done_o
);
    import burst_pkg::*;

    logic      busy_q;
    beat_idx_t beat_idx_q;
    line_t     line_q;
    logic      beat_taken;
    logic      last_beat;

    assign beat_taken = busy_q && bmem_ready_i;
    assign last_beat  = (beat_idx_q == beat_idx_t'(BEATS_PER_LINE - 1));

    // current beat stays put until memory takes it
    assign bmem_write_o = busy_q;
    assign bmem_wdata_o = line_q[beat_idx_q * BEAT_BITS +: BEAT_BITS];

    always_ff @(posedge clk) begin
        if (rst) begin
            busy_q       <= 1'b0;
            beat_idx_q   <= '0;
            write_done_o <= 1'b0;
        end else begin
            write_done_o <= beat_taken && last_beat;
            if (write_start_i) begin
                busy_q     <= 1'b1;
                beat_idx_q <= '0;
            end else if (beat_taken) begin
                beat_idx_q <= beat_idx_q + 1'b1;
                if (last_beat) begin
                    busy_q <= 1'b0;
                end
            end
        end
    end

    // line held for the whole burst
    always_ff @(posedge clk) begin
        if (write_start_i) begin
            line_q <= write_line_i;
        end
    end

endmodule

//--- hw/burst_reader.sv
`timescale 1ns/10ps

module burst_reader (
    input  logic             clk,
    input  logic             rst,
    input  logic             bmem_rvalid_i,
    input  burst_pkg::beat_t bmem_rdata_i,
    output burst_pkg::line_t read_line_o,
    output logic             read_done_o
);
    import burst_pkg::*;

    beat_idx_t beat_idx_q;
    logic      last_beat;

    assign last_beat = (beat_idx_q == beat_idx_t'(BEATS_PER_LINE - 1));

    // beat counter wraps to zero after the last beat
    always_ff @(posedge clk) begin
        if (rst) begin
            beat_idx_q  <= '0;
            read_done_o <= 1'b0;
        end else begin
            read_done_o <= bmem_rvalid_i && last_beat;
            if (bmem_rvalid_i) begin
                beat_idx_q <= beat_idx_q + 1'b1;
            end
        end
    end

    // beat k lands in bits 64k and up
    always_ff @(posedge clk) begin
        if (bmem_rvalid_i) begin
            read_line_o[beat_idx_q * BEAT_BITS +: BEAT_BITS] <= bmem_rdata_i;
        end
    end

endmodule

//--- hw/burst_pkg.sv
package burst_pkg;

    // memory port geometry
    localparam int ADDR_BITS        = 32;
    localparam int BEAT_BITS        = 64;
    localparam int BEATS_PER_LINE   = 4;
    localparam int LINE_BITS        = BEAT_BITS * BEATS_PER_LINE;
    localparam int LINE_OFFSET_BITS = 5;

    typedef logic [ADDR_BITS-1:0] addr_t;
    typedef logic [BEAT_BITS-1:0] beat_t;
    typedef logic [LINE_BITS-1:0] line_t;
    typedef logic [$clog2(BEATS_PER_LINE)-1:0] beat_idx_t;

    // data side request, read and write are exclusive
    typedef struct packed {
        addr_t addr;
        logic  read;
        logic  write;
        line_t wdata;
    } dcache_req_t;

    // resp is a one-cycle pulse, rdata valid with it on reads
    typedef struct packed {
        logic  resp;
        line_t rdata;
    } line_rsp_t;

    typedef enum logic [1:0] {
        ARB_IDLE,
        ARB_READ_I,
        ARB_READ_D,
        ARB_WRITE_D
    } arb_state_e;

endpackage
